/* project.f */
verilog/nlc_pkg.sv
verilog/nlc_channel_bank.sv
verilog/nlc_op_link.sv
verilog/nlc_sequencer.sv
verilog/nlc_top.sv
sim/nlc_tb_units.sv
sim/nlc_tb.sv

/* Makefile */
# Verilator build and run for the nonlinearity-correction controller

VERILATOR ?= verilator
TOP       ?= nlc_tb
FLAGS     ?= --binary --timing --assert
BUILD_DIR ?= obj_dir
FILELIST  ?= project.f

.PHONY: sim clean

# Passes only when the run prints the pass line
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(BUILD_DIR)

/* sim/nlc_tb.sv */
`timescale 1ns/1ps

module nlc_tb
  import nlc_pkg::*;
();

  localparam int CLK_PERIOD      = 4;
  localparam int OPS_PER_CHANNEL = 14;
  localparam int BACK_TO_BACK    = 10;
  // single_run, input_capture, one held run and the back-to-back runs
  localparam int NUM_RUNS        = 3 + BACK_TO_BACK;
  localparam int WATCHDOG_CYCLES = (NUM_RUNS + 1) * NUM_CHANNELS * OPS_PER_CHANNEL * 12;

  logic  adder_srdyo;
  logic  rst;
  logic  srdyi;
  adc_t  x_adc_in       [NUM_CHANNELS];
  word_t neg_mean_in    [NUM_CHANNELS];
  word_t recip_stdev_in [NUM_CHANNELS];
  word_t coeff_in       [NUM_CHANNELS][NUM_TERMS];
  logic  srdyo;
  adc_t  x_lin          [NUM_CHANNELS];
  logic  conv_in_req;
  adc_t  conv_in_operand;
  logic  conv_in_ack;
  word_t conv_in_result;
  logic  mul_req;
  word_t mul_a;
  word_t mul_b;
  logic  mul_ack;
  word_t mul_result;
  logic  add_req;
  word_t add_a;
  word_t add_b;
  logic  add_ack;
  word_t add_result;
  logic  conv_out_req;
  word_t conv_out_operand;
  logic  conv_out_ack;
  adc_t  conv_out_result;
  int    req_total;
  int    unit_errors;

  word_t seed;
  adc_t  exp_lin [NUM_CHANNELS];
  int    test_errors;
  int    tests_run;
  int    tests_failed;

  nlc_top nlc_top_inst (
    .adder_srdyo      (adder_srdyo),
    .rst              (rst),
    .srdyi            (srdyi),
    .x_adc_in         (x_adc_in),
    .neg_mean_in      (neg_mean_in),
    .recip_stdev_in   (recip_stdev_in),
    .coeff_in         (coeff_in),
    .srdyo            (srdyo),
    .x_lin            (x_lin),
    .conv_in_req      (conv_in_req),
    .conv_in_operand  (conv_in_operand),
    .conv_in_ack      (conv_in_ack),
    .conv_in_result   (conv_in_result),
    .mul_req          (mul_req),
    .mul_a            (mul_a),
    .mul_b            (mul_b),
    .mul_ack          (mul_ack),
    .mul_result       (mul_result),
    .add_req          (add_req),
    .add_a            (add_a),
    .add_b            (add_b),
    .add_ack          (add_ack),
    .add_result       (add_result),
    .conv_out_req     (conv_out_req),
    .conv_out_operand (conv_out_operand),
    .conv_out_ack     (conv_out_ack),
    .conv_out_result  (conv_out_result)
  );

  nlc_tb_units nlc_tb_units_inst (
    .adder_srdyo      (adder_srdyo),
    .rst              (rst),
    .conv_in_req      (conv_in_req),
    .conv_in_operand  (conv_in_operand),
    .conv_in_ack      (conv_in_ack),
    .conv_in_result   (conv_in_result),
    .mul_req          (mul_req),
    .mul_a            (mul_a),
    .mul_b            (mul_b),
    .mul_ack          (mul_ack),
    .mul_result       (mul_result),
    .add_req          (add_req),
    .add_a            (add_a),
    .add_b            (add_b),
    .add_ack          (add_ack),
    .add_result       (add_result),
    .conv_out_req     (conv_out_req),
    .conv_out_operand (conv_out_operand),
    .conv_out_ack     (conv_out_ack),
    .conv_out_result  (conv_out_result),
    .req_total        (req_total),
    .error_count      (unit_errors)
  );

  initial begin
    adder_srdyo = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      adder_srdyo = ~adder_srdyo;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the DUT finished all runs");
    $display("test failed");
    $finish;
  end

  function automatic word_t next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return {seed[15:0], seed[31:16]};
  endfunction

  // Convert, center, scale, then Horner from c5 down to c0
  function automatic adc_t corrected_sample(int ch);
    word_t norm;
    word_t acc;
    norm = word_t'(x_adc_in[ch]) + neg_mean_in[ch];
    norm = norm * recip_stdev_in[ch];
    acc  = coeff_in[ch][POLY_ORDER];
    for (int k = POLY_ORDER - 1; k >= 0; k--) begin
      acc = acc * norm + coeff_in[ch][k];
    end
    return adc_t'(acc);
  endfunction

  task automatic randomize_inputs();
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      x_adc_in[c]       = adc_t'(next_rand());
      neg_mean_in[c]    = next_rand();
      recip_stdev_in[c] = next_rand();
      for (int t = 0; t < NUM_TERMS; t++) begin
        coeff_in[c][t] = next_rand();
      end
    end
  endtask

  task automatic next_cycle();
    @(posedge adder_srdyo);
    #1;
  endtask

  task automatic check_value(string test, string what, word_t expected, word_t actual);
    assert (expected == actual) else begin
      $display("FAILED %s %s expected %h actual %h", test, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic report_test(string test);
    tests_run++;
    if (test_errors == 0) begin
      $display("%s: ok", test);
    end else begin
      $display("%s: %0d errors", test, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  task automatic check_outputs(string test);
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      check_value(test, $sformatf("x_lin[%0d]", c), word_t'(exp_lin[c]), word_t'(x_lin[c]));
    end
  endtask

  // One run up to srdyo, optionally scrambling the inputs after capture
  task automatic run_once(string test, bit scramble);
    randomize_inputs();
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      exp_lin[c] = corrected_sample(c);
    end
    srdyi = 1'b1;
    next_cycle();
    if (scramble) begin
      randomize_inputs();
    end
    while (!srdyo) begin
      next_cycle();
    end
    check_outputs(test);
  endtask

  task automatic release_host();
    srdyi = 1'b0;
    next_cycle();
    while (srdyo) begin
      next_cycle();
    end
  endtask

  task automatic hold_host(string test, int cycles);
    int reqs_before;
    reqs_before = req_total;
    repeat (cycles) begin
      next_cycle();
      check_value(test, "srdyo", 32'd1, word_t'(srdyo));
      check_outputs(test);
    end
    check_value(test, "requests while held", word_t'(reqs_before), word_t'(req_total));
  endtask

  initial begin
    seed         = 32'hae5c;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst          = 1'b1;
    srdyi        = 1'b0;
    randomize_inputs();
    repeat (5) @(posedge adder_srdyo);
    #1;
    rst = 1'b0;

    check_value("reset_state", "srdyo", 32'd0, word_t'(srdyo));
    check_value("reset_state", "req", 32'd0,
                word_t'({conv_out_req, add_req, mul_req, conv_in_req}));
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      check_value("reset_state", $sformatf("x_lin[%0d]", c), 32'd0, word_t'(x_lin[c]));
    end
    report_test("reset_state");

    run_once("single_run", 1'b0);
    release_host();
    report_test("single_run");

    run_once("input_capture", 1'b1);
    release_host();
    report_test("input_capture");

    run_once("host_handshake", 1'b0);
    hold_host("host_handshake", 20);
    release_host();
    for (int r = 0; r < BACK_TO_BACK; r++) begin
      run_once("host_handshake", 1'b0);
      release_host();
    end
    report_test("host_handshake");

    check_value("unit_protocol", "unit errors", 32'd0, word_t'(unit_errors));
    check_value("unit_protocol", "requests", word_t'(NUM_RUNS * NUM_CHANNELS * OPS_PER_CHANNEL),
                word_t'(req_total));
    report_test("unit_protocol");

    $display("%0d tests run, %0d failed", tests_run, tests_failed);
    if (tests_failed == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* sim/nlc_tb_units.sv */
`timescale 1ns/1ps

module nlc_tb_units
  import nlc_pkg::*;
(
  input  logic  adder_srdyo,
  input  logic  rst,
  input  logic  conv_in_req,
  input  adc_t  conv_in_operand,
  output logic  conv_in_ack,
  output word_t conv_in_result,
  input  logic  mul_req,
  input  word_t mul_a,
  input  word_t mul_b,
  output logic  mul_ack,
  output word_t mul_result,
  input  logic  add_req,
  input  word_t add_a,
  input  word_t add_b,
  output logic  add_ack,
  output word_t add_result,
  input  logic  conv_out_req,
  input  word_t conv_out_operand,
  output logic  conv_out_ack,
  output adc_t  conv_out_result,
  output int    req_total,
  output int    error_count
);

  // Unit index 0 conv_in, 1 mul, 2 add, 3 conv_out
  logic        req_now  [4];
  logic        req_prev [4];
  logic        ack_q    [4];
  logic        busy     [4];
  int          delay    [4];
  logic [63:0] ops_now  [4];
  logic [63:0] ops_prev [4];
  word_t       seed;

  // Integer stand-ins for the real arithmetic, valid whenever ack is high
  assign conv_in_result  = word_t'(conv_in_operand);
  assign mul_result      = mul_a * mul_b;
  assign add_result      = add_a + add_b;
  assign conv_out_result = adc_t'(conv_out_operand);

  assign conv_in_ack  = ack_q[0];
  assign mul_ack      = ack_q[1];
  assign add_ack      = ack_q[2];
  assign conv_out_ack = ack_q[3];

  function automatic word_t next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Per channel: conv_in, add, mul, five mul/add pairs, conv_out
  function automatic int expected_unit(int pos);
    if (pos == 0) begin
      return 0;
    end
    if (pos == 1) begin
      return 2;
    end
    if (pos == 2 || pos % 2 == 1) begin
      return (pos == 13) ? 3 : 1;
    end
    return 2;
  endfunction

  initial begin
    word_t r;
    seed        = 32'hae5c;
    req_total   = 0;
    error_count = 0;
    for (int u = 0; u < 4; u++) begin
      ack_q[u]    = 1'b0;
      busy[u]     = 1'b0;
      delay[u]    = 0;
      req_prev[u] = 1'b0;
      ops_prev[u] = '0;
    end
    forever begin
      @(posedge adder_srdyo);
      #1;
      req_now[0] = conv_in_req;
      req_now[1] = mul_req;
      req_now[2] = add_req;
      req_now[3] = conv_out_req;
      ops_now[0] = 64'(conv_in_operand);
      ops_now[1] = {mul_a, mul_b};
      ops_now[2] = {add_a, add_b};
      ops_now[3] = 64'(conv_out_operand);
      for (int u = 0; u < 4; u++) begin
        if (rst) begin
          ack_q[u] = 1'b0;
          busy[u]  = 1'b0;
        end else begin
          if (req_now[u] && !req_prev[u]) begin
            assert (u == expected_unit(req_total % 14)) else begin
              $display("unit %0d requested out of order at step %0d of a channel",
                       u, req_total % 14);
              error_count++;
            end
            req_total++;
          end
          assert (!(req_prev[u] && req_now[u]) || ops_now[u] == ops_prev[u]) else begin
            $display("operands of unit %0d changed while req was high", u);
            error_count++;
          end
          assert (!(req_prev[u] && !req_now[u]) || ack_q[u]) else begin
            $display("req of unit %0d dropped before ack", u);
            error_count++;
          end
          if (ack_q[u]) begin
            if (!req_now[u]) begin
              ack_q[u] = 1'b0;
            end
          end else if (busy[u]) begin
            if (delay[u] == 0) begin
              ack_q[u] = 1'b1;
              busy[u]  = 1'b0;
            end else begin
              delay[u]--;
            end
          end else if (req_now[u]) begin
            r        = next_rand();
            busy[u]  = 1'b1;
            delay[u] = int'(r[18:16]);
          end
        end
        req_prev[u] = req_now[u];
        ops_prev[u] = ops_now[u];
      end
    end
  end

endmodule

/* verilog/nlc_top.sv */
`timescale 1ns/1ps

module nlc_top
  import nlc_pkg::*;
(
  input  logic  adder_srdyo,
  input  logic  rst,
  input  logic  srdyi,
  input  adc_t  x_adc_in       [NUM_CHANNELS],
  input  word_t neg_mean_in    [NUM_CHANNELS],
  input  word_t recip_stdev_in [NUM_CHANNELS],
  input  word_t coeff_in       [NUM_CHANNELS][NUM_TERMS],
  output logic  srdyo,
  output adc_t  x_lin          [NUM_CHANNELS],
  output logic  conv_in_req,
  output adc_t  conv_in_operand,
  input  logic  conv_in_ack,
  input  word_t conv_in_result,
  output logic  mul_req,
  output word_t mul_a,
  output word_t mul_b,
  input  logic  mul_ack,
  input  word_t mul_result,
  output logic  add_req,
  output word_t add_a,
  output word_t add_b,
  input  logic  add_ack,
  input  word_t add_result,
  output logic  conv_out_req,
  output word_t conv_out_operand,
  input  logic  conv_out_ack,
  input  adc_t  conv_out_result
);

  logic  capture;
  chan_t rd_chan;
  term_t rd_term;
  word_t rd_neg_mean;
  word_t rd_recip_stdev;
  word_t rd_coeff;
  logic  wr_en;
  chan_t wr_chan;
  adc_t  wr_data;
  logic  issue_conv_in;
  logic  issue_mul;
  logic  issue_add;
  logic  issue_conv_out;
  logic  done_conv_in;
  logic  done_mul;
  logic  done_add;
  logic  done_conv_out;
  word_t res_conv_in;
  word_t res_mul;
  word_t res_add;
  word_t res_conv_out;

  // Final Horner sum stays in the adder link while it is converted back
  assign conv_out_operand = res_add;

  nlc_channel_bank nlc_channel_bank_inst (
    .adder_srdyo    (adder_srdyo),
    .rst            (rst),
    .capture        (capture),
    .x_adc_in       (x_adc_in),
    .neg_mean_in    (neg_mean_in),
    .recip_stdev_in (recip_stdev_in),
    .coeff_in       (coeff_in),
    .rd_chan        (rd_chan),
    .rd_term        (rd_term),
    .rd_sample      (conv_in_operand),
    .rd_neg_mean    (rd_neg_mean),
    .rd_recip_stdev (rd_recip_stdev),
    .rd_coeff       (rd_coeff),
    .wr_en          (wr_en),
    .wr_chan        (wr_chan),
    .wr_data        (wr_data),
    .x_lin          (x_lin)
  );

  nlc_sequencer nlc_sequencer_inst (
    .adder_srdyo    (adder_srdyo),
    .rst            (rst),
    .srdyi          (srdyi),
    .srdyo          (srdyo),
    .capture        (capture),
    .rd_chan        (rd_chan),
    .rd_term        (rd_term),
    .rd_sample      (conv_in_operand),
    .rd_neg_mean    (rd_neg_mean),
    .rd_recip_stdev (rd_recip_stdev),
    .rd_coeff       (rd_coeff),
    .wr_en          (wr_en),
    .wr_chan        (wr_chan),
    .wr_data        (wr_data),
    .issue_conv_in  (issue_conv_in),
    .issue_mul      (issue_mul),
    .issue_add      (issue_add),
    .issue_conv_out (issue_conv_out),
    .done_conv_in   (done_conv_in),
    .done_mul       (done_mul),
    .done_add       (done_add),
    .done_conv_out  (done_conv_out),
    .res_conv_in    (res_conv_in),
    .res_mul        (res_mul),
    .res_add        (res_add),
    .res_conv_out   (adc_t'(res_conv_out)),
    .mul_a          (mul_a),
    .mul_b          (mul_b),
    .add_a          (add_a),
    .add_b          (add_b)
  );

  nlc_op_link conv_in_link_inst (
    .adder_srdyo (adder_srdyo),
    .rst         (rst),
    .issue       (issue_conv_in),
    .req         (conv_in_req),
    .ack         (conv_in_ack),
    .result_in   (conv_in_result),
    .result      (res_conv_in),
    .done        (done_conv_in)
  );

  nlc_op_link mul_link_inst (
    .adder_srdyo (adder_srdyo),
    .rst         (rst),
    .issue       (issue_mul),
    .req         (mul_req),
    .ack         (mul_ack),
    .result_in   (mul_result),
    .result      (res_mul),
    .done        (done_mul)
  );

  nlc_op_link add_link_inst (
    .adder_srdyo (adder_srdyo),
    .rst         (rst),
    .issue       (issue_add),
    .req         (add_req),
    .ack         (add_ack),
    .result_in   (add_result),
    .result      (res_add),
    .done        (done_add)
  );

  // Sample result zero padded into the word-wide link
  nlc_op_link conv_out_link_inst (
    .adder_srdyo (adder_srdyo),
    .rst         (rst),
    .issue       (issue_conv_out),
    .req         (conv_out_req),
    .ack         (conv_out_ack),
    .result_in   (word_t'(conv_out_result)),
    .result      (res_conv_out),
    .done        (done_conv_out)
  );

endmodule

/* verilog/nlc_sequencer.sv */
`timescale 1ns/1ps

module nlc_sequencer
  import nlc_pkg::*;
(
  input  logic  adder_srdyo,
  input  logic  rst,
  input  logic  srdyi,
  output logic  srdyo,
  output logic  capture,
  output chan_t rd_chan,
  output term_t rd_term,
  input  adc_t  rd_sample,
  input  word_t rd_neg_mean,
  input  word_t rd_recip_stdev,
  input  word_t rd_coeff,
  output logic  wr_en,
  output chan_t wr_chan,
  output adc_t  wr_data,
  output logic  issue_conv_in,
  output logic  issue_mul,
  output logic  issue_add,
  output logic  issue_conv_out,
  input  logic  done_conv_in,
  input  logic  done_mul,
  input  logic  done_add,
  input  logic  done_conv_out,
  input  word_t res_conv_in,
  input  word_t res_mul,
  input  word_t res_add,
  input  adc_t  res_conv_out,
  output word_t mul_a,
  output word_t mul_b,
  output word_t add_a,
  output word_t add_b
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_CONVERT,
    S_CENTER,
    S_SCALE,
    S_POLY_MUL,
    S_POLY_ADD,
    S_CONVERT_BACK,
    S_FINISH
  } state_t;

  state_t state;
  chan_t  chan;
  term_t  term;
  word_t  norm;
  word_t  acc;

  assign srdyo   = (state == S_FINISH);
  assign capture = (state == S_IDLE) && srdyi;
  assign rd_chan = chan;
  assign rd_term = term;

  assign wr_en   = (state == S_CONVERT_BACK) && done_conv_out;
  assign wr_chan = chan;
  assign wr_data = res_conv_out;

  // Operands come from held link results, local registers or the bank
  always_comb begin
    add_a = res_conv_in;
    add_b = rd_neg_mean;
    mul_a = res_add;
    mul_b = rd_recip_stdev;
    if (state == S_POLY_ADD) begin
      add_a = res_mul;
      add_b = rd_coeff;
    end
    if (state == S_POLY_MUL) begin
      mul_a = acc;
      mul_b = norm;
    end
  end

  always_ff @(posedge adder_srdyo) begin
    if (rst) begin
      state          <= S_IDLE;
      chan           <= '0;
      term           <= term_t'(POLY_ORDER);
      issue_conv_in  <= 1'b0;
      issue_mul      <= 1'b0;
      issue_add      <= 1'b0;
      issue_conv_out <= 1'b0;
    end else begin
      issue_conv_in  <= 1'b0;
      issue_mul      <= 1'b0;
      issue_add      <= 1'b0;
      issue_conv_out <= 1'b0;
      case (state)
        S_IDLE: begin
          if (srdyi) begin
            chan          <= '0;
            term          <= term_t'(POLY_ORDER);
            issue_conv_in <= 1'b1;
            state         <= S_CONVERT;
          end
        end
        S_CONVERT: begin
          if (done_conv_in) begin
            issue_add <= 1'b1;
            state     <= S_CENTER;
          end
        end
        S_CENTER: begin
          if (done_add) begin
            issue_mul <= 1'b1;
            state     <= S_SCALE;
          end
        end
        S_SCALE: begin
          if (done_mul) begin
            issue_mul <= 1'b1;
            state     <= S_POLY_MUL;
          end
        end
        S_POLY_MUL: begin
          if (done_mul) begin
            term      <= term - term_t'(1);
            issue_add <= 1'b1;
            state     <= S_POLY_ADD;
          end
        end
        S_POLY_ADD: begin
          if (done_add) begin
            // Horner loop ends once c0 is added
            if (term == '0) begin
              issue_conv_out <= 1'b1;
              state          <= S_CONVERT_BACK;
            end else begin
              issue_mul <= 1'b1;
              state     <= S_POLY_MUL;
            end
          end
        end
        S_CONVERT_BACK: begin
          if (done_conv_out) begin
            if (chan == chan_t'(NUM_CHANNELS - 1)) begin
              state <= S_FINISH;
            end else begin
              chan          <= chan + chan_t'(1);
              term          <= term_t'(POLY_ORDER);
              issue_conv_in <= 1'b1;
              state         <= S_CONVERT;
            end
          end
        end
        S_FINISH: begin
          // Wait for the host to drop its request
          if (!srdyi) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Normalized value and Horner accumulator starting from c5
  always_ff @(posedge adder_srdyo) begin
    if (state == S_SCALE && done_mul) begin
      norm <= res_mul;
      acc  <= rd_coeff;
    end
    if (state == S_POLY_ADD && done_add) begin
      acc <= res_add;
    end
  end

  a_one_issue: assert property (@(posedge adder_srdyo) disable iff (rst)
    $onehot0({issue_conv_in, issue_mul, issue_add, issue_conv_out}));

  // Bank sample feeds the input converter and must not move mid-request
  a_sample_stable: assert property (@(posedge adder_srdyo) disable iff (rst)
    state == S_CONVERT && !issue_conv_in |-> $stable(rd_sample));

endmodule

/* verilog/nlc_op_link.sv */
`timescale 1ns/1ps

module nlc_op_link
  import nlc_pkg::*;
(
  input  logic  adder_srdyo,
  input  logic  rst,
  input  logic  issue,
  output logic  req,
  input  logic  ack,
  input  word_t result_in,
  output word_t result,
  output logic  done
);

  typedef enum logic [1:0] {
    L_IDLE,
    L_WAIT_HI,
    L_WAIT_LO
  } link_state_t;

  link_state_t state;

  // Four-phase handshake towards one arithmetic unit
  always_ff @(posedge adder_srdyo) begin
    if (rst) begin
      state <= L_IDLE;
      req   <= 1'b0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        L_IDLE: begin
          if (issue) begin
            req   <= 1'b1;
            state <= L_WAIT_HI;
          end
        end
        L_WAIT_HI: begin
          if (ack) begin
            req   <= 1'b0;
            state <= L_WAIT_LO;
          end
        end
        L_WAIT_LO: begin
          // Unit has released, operation is complete
          if (!ack) begin
            done  <= 1'b1;
            state <= L_IDLE;
          end
        end
        default: state <= L_IDLE;
      endcase
    end
  end

  // Result is valid with ack and held until the next issue
  always_ff @(posedge adder_srdyo) begin
    if (state == L_WAIT_HI && ack) begin
      result <= result_in;
    end
  end

  a_issue_in_idle: assert property (@(posedge adder_srdyo) disable iff (rst)
    issue |-> state == L_IDLE);

  a_req_held: assert property (@(posedge adder_srdyo) disable iff (rst)
    req && !ack |=> req);

endmodule

/* verilog/nlc_channel_bank.sv */
`timescale 1ns/1ps

module nlc_channel_bank
  import nlc_pkg::*;
(
  input  logic  adder_srdyo,
  input  logic  rst,
  input  logic  capture,
  input  adc_t  x_adc_in       [NUM_CHANNELS],
  input  word_t neg_mean_in    [NUM_CHANNELS],
  input  word_t recip_stdev_in [NUM_CHANNELS],
  input  word_t coeff_in       [NUM_CHANNELS][NUM_TERMS],
  input  chan_t rd_chan,
  input  term_t rd_term,
  output adc_t  rd_sample,
  output word_t rd_neg_mean,
  output word_t rd_recip_stdev,
  output word_t rd_coeff,
  input  logic  wr_en,
  input  chan_t wr_chan,
  input  adc_t  wr_data,
  output adc_t  x_lin          [NUM_CHANNELS]
);

  adc_t  sample_q      [NUM_CHANNELS];
  word_t neg_mean_q    [NUM_CHANNELS];
  word_t recip_stdev_q [NUM_CHANNELS];
  word_t coeff_q       [NUM_CHANNELS][NUM_TERMS];

  // Host inputs are free to change once a run has started
  always_ff @(posedge adder_srdyo) begin
    if (capture) begin
      sample_q      <= x_adc_in;
      neg_mean_q    <= neg_mean_in;
      recip_stdev_q <= recip_stdev_in;
      coeff_q       <= coeff_in;
    end
  end

  // Selected channel for the sequencer
  assign rd_sample      = sample_q[rd_chan];
  assign rd_neg_mean    = neg_mean_q[rd_chan];
  assign rd_recip_stdev = recip_stdev_q[rd_chan];
  assign rd_coeff       = coeff_q[rd_chan][rd_term];

  // Corrected samples, held between runs
  always_ff @(posedge adder_srdyo) begin
    if (rst) begin
      x_lin <= '{default: '0};
    end else if (wr_en) begin
      x_lin[wr_chan] <= wr_data;
    end
  end

endmodule

/* verilog/nlc_pkg.sv */
package nlc_pkg;

  // Raw ADC sample and corrected output width
  localparam int ADC_WIDTH = 21;

  // Working word used by the external converter, multiplier and adder
  localparam int WORD_WIDTH = 32;

  localparam int NUM_CHANNELS = 4;

  // Fifth-order correction polynomial
  localparam int POLY_ORDER = 5;
  localparam int NUM_TERMS = POLY_ORDER + 1;

  // Raw or corrected sample
  typedef logic [ADC_WIDTH-1:0] adc_t;

  // Working word, format is opaque to the controller
  typedef logic [WORD_WIDTH-1:0] word_t;

  // Channel index, wide enough for NUM_CHANNELS
  typedef logic [1:0] chan_t;

  // Coefficient index, counts POLY_ORDER down to 0
  typedef logic [2:0] term_t;

endpackage
